//--- common/core_pkg.sv
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int NUM_LANES  = 2;

    // Major opcodes of the 3R format in bits 31 to 15
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_SLT   = 17'h00024;
    localparam logic [16:0] OP_SLTU  = 17'h00025;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002A;
    localparam logic [16:0] OP_XOR   = 17'h0002B;

    // Opcodes of the 2RI12 format in bits 31 to 22
    localparam logic [9:0] OP_ADDI_W = 10'h00A;
    localparam logic [9:0] OP_ANDI   = 10'h00D;
    localparam logic [9:0] OP_ORI    = 10'h00E;
    localparam logic [9:0] OP_XORI   = 10'h00F;

    typedef struct packed {
        logic [16:0]           opcode17;
        logic [REG_ADDR_W-1:0] rk;
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rd;
    } instr_3r_t;

    typedef struct packed {
        logic [9:0]            opcode10;
        logic [11:0]           imm12;    // Extension depends on the opcode
        logic [REG_ADDR_W-1:0] rj;
        logic [REG_ADDR_W-1:0] rd;
    } instr_2ri12_t;

    // Same 32-bit word seen in either format
    typedef union packed {
        instr_3r_t    r3;
        instr_2ri12_t ri12;
    } instr_u;

    // Supported register-register op
    function automatic logic is_3r_op(instr_u ins);
        return ins.r3.opcode17 inside {OP_ADD_W, OP_SUB_W, OP_SLT, OP_SLTU,
                                       OP_AND, OP_OR, OP_XOR};
    endfunction

    // Supported immediate op
    function automatic logic is_2ri_op(instr_u ins);
        return ins.ri12.opcode10 inside {OP_ADDI_W, OP_ANDI, OP_ORI, OP_XORI};
    endfunction

endpackage

//--- common/pipe_if.sv
`timescale 1ns/1ps

// One instruction with its operands, dispatch to lane
interface lane_issue_if import core_pkg::*; ();

    logic            valid;
    logic [XLEN-1:0] pc;
    instr_u          instr;
    logic [XLEN-1:0] rj_data;
    logic [XLEN-1:0] rk_data;

    modport dispatch (
        output valid, pc, instr, rj_data, rk_data
    );

    modport lane (
        input valid, pc, instr, rj_data, rk_data
    );

endinterface

// One computed result, lane to commit
interface lane_result_if import core_pkg::*; ();

    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;

    modport lane (
        output valid, pc, we, waddr, wdata
    );

    modport commit (
        input valid, pc, we, waddr, wdata
    );

endinterface

//--- hw/dispatch.sv
`timescale 1ns/1ps

module dispatch import core_pkg::*; (
    input  logic                                   clk,
    input  logic                                   reset_i,

    input  logic                                   issue_valid_i,
    input  logic [XLEN-1:0]                        issue_pc_i,
    input  instr_u                                 issue_instr0_i,
    input  instr_u                                 issue_instr1_i,
    output logic                                   issue_ready_o,

    output logic [2*NUM_LANES-1:0][REG_ADDR_W-1:0] rd_addr_o,
    input  logic [2*NUM_LANES-1:0][XLEN-1:0]       rd_data_i,

    lane_issue_if.dispatch                         lane0_o,
    lane_issue_if.dispatch                         lane1_o
);

    logic            valid_q;   // Pair present in dispatch register
    logic            held_q;    // Slot 0 already sent, slot 1 waiting
    logic [XLEN-1:0] pc_q;
    instr_u          instr0_q;
    instr_u          instr1_q;

    logic            slot0_writes;
    logic            rj_hit;
    logic            rk_hit;
    logic            split;

    // Intra-pair RAW check on the stored pair
    assign slot0_writes = (is_3r_op(instr0_q) || is_2ri_op(instr0_q)) && instr0_q.r3.rd != '0;
    assign rj_hit = (is_3r_op(instr1_q) || is_2ri_op(instr1_q))
                    && instr1_q.r3.rj == instr0_q.r3.rd;
    assign rk_hit = is_3r_op(instr1_q) && instr1_q.r3.rk == instr0_q.r3.rd;  // 3R only reads rk

    assign split         = valid_q && !held_q && slot0_writes && (rj_hit || rk_hit);
    assign issue_ready_o = !split;  // Stall one cycle to send slot 1 alone

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
            held_q  <= 1'b0;
        end else if (split) begin
            held_q <= 1'b1;  // Keep slot 1 for the next cycle
        end else begin
            valid_q <= issue_valid_i;
            held_q  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid_i && issue_ready_o) begin
            pc_q     <= issue_pc_i;
            instr0_q <= issue_instr0_i;
            instr1_q <= issue_instr1_i;
        end
    end

    // Two read ports per slot, rj then rk
    assign rd_addr_o[0] = instr0_q.r3.rj;
    assign rd_addr_o[1] = instr0_q.r3.rk;
    assign rd_addr_o[2] = instr1_q.r3.rj;
    assign rd_addr_o[3] = instr1_q.r3.rk;

    assign lane0_o.valid   = valid_q && !held_q;
    assign lane0_o.pc      = pc_q;
    assign lane0_o.instr   = instr0_q;
    assign lane0_o.rj_data = rd_data_i[0];
    assign lane0_o.rk_data = rd_data_i[1];

    assign lane1_o.valid   = valid_q && !split;
    assign lane1_o.pc      = pc_q + XLEN'(4);  // Slot 1 is the next word
    assign lane1_o.instr   = instr1_q;
    assign lane1_o.rj_data = rd_data_i[2];
    assign lane1_o.rk_data = rd_data_i[3];

endmodule

//--- hw/regfile.sv
`timescale 1ns/1ps

module regfile import core_pkg::*; (
    input  logic                                   clk,
    input  logic                                   reset_i,

    input  logic [2*NUM_LANES-1:0][REG_ADDR_W-1:0] rd_addr_i,
    output logic [2*NUM_LANES-1:0][XLEN-1:0]       rd_data_o,

    input  logic [NUM_LANES-1:0]                   we_i,
    input  logic [NUM_LANES-1:0][REG_ADDR_W-1:0]   waddr_i,
    input  logic [NUM_LANES-1:0][XLEN-1:0]         wdata_i
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // Slot 1 is written last so it wins on a clash
            for (int p = 0; p < NUM_LANES; p++) begin
                if (we_i[p] && waddr_i[p] != '0) begin
                    regs[waddr_i[p]] <= wdata_i[p];
                end
            end
        end
    end

    // Read with bypass of the writes pending this cycle
    always_comb begin
        for (int i = 0; i < 2*NUM_LANES; i++) begin
            rd_data_o[i] = regs[rd_addr_i[i]];
            for (int p = 0; p < NUM_LANES; p++) begin
                if (we_i[p] && waddr_i[p] == rd_addr_i[i]) begin
                    rd_data_o[i] = wdata_i[p];  // Later slot overrides
                end
            end
            if (rd_addr_i[i] == '0) begin
                rd_data_o[i] = '0;  // r0 is hardwired
            end
        end
    end

endmodule

//--- hw/lane/alu_lane.sv
`timescale 1ns/1ps

module alu_lane import core_pkg::*; (
    lane_issue_if.lane  issue_i,
    lane_result_if.lane result_o
);

    instr_u          ins;
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] imm_sext;
    logic [XLEN-1:0] imm_zext;
    logic [XLEN-1:0] result;
    logic            is_3r;
    logic            is_2ri;

    assign ins   = issue_i.instr;
    assign src_a = issue_i.rj_data;
    assign src_b = issue_i.rk_data;

    assign imm_sext = {{(XLEN-12){ins.ri12.imm12[11]}}, ins.ri12.imm12};  // ADDI.W
    assign imm_zext = {{(XLEN-12){1'b0}}, ins.ri12.imm12};                 // Logic immediates

    assign is_3r  = is_3r_op(ins);
    assign is_2ri = is_2ri_op(ins);

    always_comb begin
        result = '0;
        if (is_3r) begin
            case (ins.r3.opcode17)
                OP_ADD_W: result = src_a + src_b;
                OP_SUB_W: result = src_a - src_b;
                OP_SLT:   result = {{(XLEN-1){1'b0}}, ($signed(src_a) < $signed(src_b))};
                OP_SLTU:  result = {{(XLEN-1){1'b0}}, (src_a < src_b)};
                OP_AND:   result = src_a & src_b;
                OP_OR:    result = src_a | src_b;
                OP_XOR:   result = src_a ^ src_b;
                default:  result = '0;
            endcase
        end else if (is_2ri) begin
            case (ins.ri12.opcode10)
                OP_ADDI_W: result = src_a + imm_sext;
                OP_ANDI:   result = src_a & imm_zext;
                OP_ORI:    result = src_a | imm_zext;
                OP_XORI:   result = src_a ^ imm_zext;
                default:   result = '0;
            endcase
        end
    end

    // Unknown encodings still commit but never write
    assign result_o.valid = issue_i.valid;
    assign result_o.pc    = issue_i.pc;
    assign result_o.we    = issue_i.valid && (is_3r || is_2ri) && ins.r3.rd != '0;
    assign result_o.waddr = ins.r3.rd;
    assign result_o.wdata = result;

endmodule

//--- hw/commit.sv
`timescale 1ns/1ps

module commit import core_pkg::*; (
    input  logic                                 clk,
    input  logic                                 reset_i,

    lane_result_if.commit                        lane0_i,
    lane_result_if.commit                        lane1_i,

    output logic [NUM_LANES-1:0]                 rf_we_o,
    output logic [NUM_LANES-1:0][REG_ADDR_W-1:0] rf_waddr_o,
    output logic [NUM_LANES-1:0][XLEN-1:0]       rf_wdata_o,

    output logic                                 debug0_wb_valid_o,
    output logic [XLEN-1:0]                      debug0_wb_pc_o,
    output logic                                 debug0_wb_rf_wen_o,
    output logic [REG_ADDR_W-1:0]                debug0_wb_rf_wnum_o,
    output logic [XLEN-1:0]                      debug0_wb_rf_wdata_o,
    output logic                                 debug1_wb_valid_o,
    output logic [XLEN-1:0]                      debug1_wb_pc_o,
    output logic                                 debug1_wb_rf_wen_o,
    output logic [REG_ADDR_W-1:0]                debug1_wb_rf_wnum_o,
    output logic [XLEN-1:0]                      debug1_wb_rf_wdata_o
);

    logic [NUM_LANES-1:0]                 valid_q;
    logic [NUM_LANES-1:0]                 we_q;
    logic [NUM_LANES-1:0][XLEN-1:0]       pc_q;
    logic [NUM_LANES-1:0][REG_ADDR_W-1:0] waddr_q;
    logic [NUM_LANES-1:0][XLEN-1:0]       wdata_q;
    logic                                 same_dst;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
            we_q    <= '0;
        end else begin
            valid_q <= {lane1_i.valid, lane0_i.valid};
            we_q    <= {lane1_i.we, lane0_i.we};
        end
    end

    always_ff @(posedge clk) begin
        pc_q    <= {lane1_i.pc, lane0_i.pc};
        waddr_q <= {lane1_i.waddr, lane0_i.waddr};
        wdata_q <= {lane1_i.wdata, lane0_i.wdata};
    end

    // Slot 1 overwrites the same register, so slot 0 is dropped
    assign same_dst = we_q[1] && waddr_q[1] == waddr_q[0];

    assign rf_we_o    = {we_q[1], we_q[0] && !same_dst};
    assign rf_waddr_o = waddr_q;
    assign rf_wdata_o = wdata_q;

    // Debug ports report both writes as executed
    assign debug0_wb_valid_o    = valid_q[0];
    assign debug0_wb_pc_o       = pc_q[0];
    assign debug0_wb_rf_wen_o   = we_q[0];
    assign debug0_wb_rf_wnum_o  = waddr_q[0];
    assign debug0_wb_rf_wdata_o = wdata_q[0];

    assign debug1_wb_valid_o    = valid_q[1];
    assign debug1_wb_pc_o       = pc_q[1];
    assign debug1_wb_rf_wen_o   = we_q[1];
    assign debug1_wb_rf_wnum_o  = waddr_q[1];
    assign debug1_wb_rf_wdata_o = wdata_q[1];

endmodule

//--- hw/core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,

    // Instruction pair from the buffer
    input  logic                  issue_valid_i,
    input  logic [XLEN-1:0]       issue_pc_i,
    input  logic [XLEN-1:0]       issue_instr0_i,
    input  logic [XLEN-1:0]       issue_instr1_i,
    output logic                  issue_ready_o,

    // Commit ports
    output logic                  debug0_wb_valid_o,
    output logic [XLEN-1:0]       debug0_wb_pc_o,
    output logic                  debug0_wb_rf_wen_o,
    output logic [REG_ADDR_W-1:0] debug0_wb_rf_wnum_o,
    output logic [XLEN-1:0]       debug0_wb_rf_wdata_o,
    output logic                  debug1_wb_valid_o,
    output logic [XLEN-1:0]       debug1_wb_pc_o,
    output logic                  debug1_wb_rf_wen_o,
    output logic [REG_ADDR_W-1:0] debug1_wb_rf_wnum_o,
    output logic [XLEN-1:0]       debug1_wb_rf_wdata_o
);

    logic [2*NUM_LANES-1:0][REG_ADDR_W-1:0] rd_addr;
    logic [2*NUM_LANES-1:0][XLEN-1:0]       rd_data;
    logic [NUM_LANES-1:0]                   rf_we;
    logic [NUM_LANES-1:0][REG_ADDR_W-1:0]   rf_waddr;
    logic [NUM_LANES-1:0][XLEN-1:0]         rf_wdata;

    lane_issue_if  issue0 ();
    lane_issue_if  issue1 ();
    lane_result_if result0 ();
    lane_result_if result1 ();

    dispatch u_dispatch (
        .clk           (clk),
        .reset_i       (reset_i),
        .issue_valid_i (issue_valid_i),
        .issue_pc_i    (issue_pc_i),
        .issue_instr0_i(issue_instr0_i),
        .issue_instr1_i(issue_instr1_i),
        .issue_ready_o (issue_ready_o),
        .rd_addr_o     (rd_addr),
        .rd_data_i     (rd_data),
        .lane0_o       (issue0.dispatch),
        .lane1_o       (issue1.dispatch)
    );

    regfile u_regfile (
        .clk      (clk),
        .reset_i  (reset_i),
        .rd_addr_i(rd_addr),
        .rd_data_o(rd_data),
        .we_i     (rf_we),     // From commit, also bypassed to reads
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata)
    );

    alu_lane u_lane0 (
        .issue_i (issue0.lane),
        .result_o(result0.lane)
    );

    alu_lane u_lane1 (
        .issue_i (issue1.lane),
        .result_o(result1.lane)
    );

    commit u_commit (
        .clk                 (clk),
        .reset_i             (reset_i),
        .lane0_i             (result0.commit),
        .lane1_i             (result1.commit),
        .rf_we_o             (rf_we),
        .rf_waddr_o          (rf_waddr),
        .rf_wdata_o          (rf_wdata),
        .debug0_wb_valid_o   (debug0_wb_valid_o),
        .debug0_wb_pc_o      (debug0_wb_pc_o),
        .debug0_wb_rf_wen_o  (debug0_wb_rf_wen_o),
        .debug0_wb_rf_wnum_o (debug0_wb_rf_wnum_o),
        .debug0_wb_rf_wdata_o(debug0_wb_rf_wdata_o),
        .debug1_wb_valid_o   (debug1_wb_valid_o),
        .debug1_wb_pc_o      (debug1_wb_pc_o),
        .debug1_wb_rf_wen_o  (debug1_wb_rf_wen_o),
        .debug1_wb_rf_wnum_o (debug1_wb_rf_wnum_o),
        .debug1_wb_rf_wdata_o(debug1_wb_rf_wdata_o)
    );

endmodule

//--- test/core_sva.sv
`timescale 1ns/1ps

module core_sva import core_pkg::*; (
    input logic                  clk,
    input logic                  reset_i,
    input logic                  ready_i,
    input logic                  valid0_i,
    input logic                  wen0_i,
    input logic [REG_ADDR_W-1:0] wnum0_i,
    input logic                  valid1_i,
    input logic                  wen1_i,
    input logic [REG_ADDR_W-1:0] wnum1_i
);

    // A split stalls the source for one cycle only
    ready_one_cycle: assert property (@(posedge clk) disable iff (reset_i) !ready_i |=> ready_i)
        else $error("issue_ready_o stayed low for two cycles");

    wen0_valid: assert property (@(posedge clk) disable iff (reset_i) wen0_i |-> valid0_i)
        else $error("debug0 write enable without valid");
    wen1_valid: assert property (@(posedge clk) disable iff (reset_i) wen1_i |-> valid1_i)
        else $error("debug1 write enable without valid");

    wen0_nonzero: assert property (@(posedge clk) disable iff (reset_i) wen0_i |-> wnum0_i != '0)
        else $error("debug0 reports a write to r0");
    wen1_nonzero: assert property (@(posedge clk) disable iff (reset_i) wen1_i |-> wnum1_i != '0)
        else $error("debug1 reports a write to r0");

    ready_after_reset: assert property (@(posedge clk) $fell(reset_i) |-> ready_i)
        else $error("issue_ready_o low in the first cycle after reset");

endmodule

bind core_top core_sva u_sva (
    .clk     (clk),
    .reset_i (reset_i),
    .ready_i (issue_ready_o),
    .valid0_i(debug0_wb_valid_o),
    .wen0_i  (debug0_wb_rf_wen_o),
    .wnum0_i (debug0_wb_rf_wnum_o),
    .valid1_i(debug1_wb_valid_o),
    .wen1_i  (debug1_wb_rf_wen_o),
    .wnum1_i (debug1_wb_rf_wnum_o)
);

//--- test/core_tb.sv
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

    localparam int NUM_PAIRS  = 300;
    localparam int SEED       = 35;
    localparam int CLK_PERIOD = 20;
    localparam int MAX_CYCLES = NUM_PAIRS * NUM_LANES * 4 + 100;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic                  wen;
        logic [REG_ADDR_W-1:0] wnum;
        logic [XLEN-1:0]       wdata;
        logic                  slot;
        int                    cyc;   // Edge where the commit must be seen
    } commit_t;

    logic                  clk = 1'b0;
    logic                  reset_i;
    logic                  issue_valid_i;
    logic [XLEN-1:0]       issue_pc_i;
    logic [XLEN-1:0]       issue_instr0_i;
    logic [XLEN-1:0]       issue_instr1_i;
    logic                  issue_ready_o;
    logic                  debug0_wb_valid_o;
    logic [XLEN-1:0]       debug0_wb_pc_o;
    logic                  debug0_wb_rf_wen_o;
    logic [REG_ADDR_W-1:0] debug0_wb_rf_wnum_o;
    logic [XLEN-1:0]       debug0_wb_rf_wdata_o;
    logic                  debug1_wb_valid_o;
    logic [XLEN-1:0]       debug1_wb_pc_o;
    logic                  debug1_wb_rf_wen_o;
    logic [REG_ADDR_W-1:0] debug1_wb_rf_wnum_o;
    logic [XLEN-1:0]       debug1_wb_rf_wdata_o;

    logic [XLEN-1:0] model_regs [NUM_REGS];   // Sequential reference state
    commit_t         exp_q [$];
    logic [16:0]     rr_ops [7] = '{OP_ADD_W, OP_SUB_W, OP_SLT, OP_SLTU, OP_AND, OP_OR, OP_XOR};
    logic [9:0]      ri_ops [4] = '{OP_ADDI_W, OP_ANDI, OP_ORI, OP_XORI};
    logic [XLEN-1:0] next_pc = 32'h1c00_0000;
    logic            exp_ready = 1'b1;
    int              cyc_cnt = 0;
    int              pairs_sent = 0;
    int              checked = 0;
    int              value_errors = 0;
    int              timing_errors = 0;

    core_top UUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // 0 unknown, 1 register-register, 2 immediate
    function automatic int op_kind(input logic [31:0] w);
        if (w[31:15] inside {OP_ADD_W, OP_SUB_W, OP_SLT, OP_SLTU, OP_AND, OP_OR, OP_XOR}) begin
            return 1;
        end
        return (w[31:22] inside {OP_ADDI_W, OP_ANDI, OP_ORI, OP_XORI}) ? 2 : 0;
    endfunction

    function automatic logic [31:0] ref_value(input logic [31:0] w, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [31:0] zx;
        zx = {20'd0, w[21:10]};
        if (op_kind(w) == 2) begin
            case (w[31:22])
                OP_ADDI_W: return a + {{20{w[21]}}, w[21:10]};
                OP_ANDI:   return a & zx;
                OP_ORI:    return a | zx;
                default:   return a ^ zx;
            endcase
        end
        case (w[31:15])
            OP_ADD_W: return a + b;
            OP_SUB_W: return a - b;
            OP_SLT:   return {31'd0, $signed(a) < $signed(b)};
            OP_SLTU:  return {31'd0, a < b};
            OP_AND:   return a & b;
            OP_OR:    return a | b;
            OP_XOR:   return a ^ b;
            default:  return '0;
        endcase
    endfunction

    // Slot 1 reads the register that slot 0 writes
    function automatic logic pair_dependent(input logic [31:0] w0, input logic [31:0] w1);
        logic [4:0] rd0;
        rd0 = w0[4:0];
        if (op_kind(w0) == 0 || rd0 == 5'd0 || op_kind(w1) == 0) begin
            return 1'b0;
        end
        return w1[9:5] == rd0 || (op_kind(w1) == 1 && w1[14:10] == rd0);
    endfunction

    function automatic logic [31:0] random_instr();
        logic [4:0] rd;
        logic [4:0] rj;
        logic [2:0] rr_sel;
        logic [1:0] ri_sel;
        int         kind;
        rd     = 5'($urandom_range(0, 7));   // Few registers give frequent dependences
        rj     = 5'($urandom_range(0, 7));
        rr_sel = 3'($urandom_range(0, 6));
        ri_sel = 2'($urandom);
        kind   = int'($urandom_range(0, 12));
        if (kind < 7) begin
            return {rr_ops[rr_sel], 5'($urandom_range(0, 7)), rj, rd};
        end else if (kind < 11) begin
            return {ri_ops[ri_sel], 12'($urandom), rj, rd};
        end
        return {10'h3FF, 12'($urandom), rj, rd};   // Unknown encoding
    endfunction

    task automatic model_execute(input logic [31:0] w, input logic [31:0] pc, input logic slot,
                                 input int cyc);
        commit_t c;
        c.pc    = pc;
        c.wen   = op_kind(w) != 0 && w[4:0] != 5'd0;
        c.wnum  = w[4:0];
        c.wdata = ref_value(w, model_regs[w[9:5]], model_regs[w[14:10]]);
        c.slot  = slot;
        c.cyc   = cyc;
        if (c.wen) begin
            model_regs[w[4:0]] = c.wdata;
        end
        exp_q.push_back(c);
    endtask

    task automatic check_slot(input logic slot, input logic valid, input logic [31:0] pc,
                              input logic wen, input logic [4:0] wnum, input logic [31:0] wdata);
        commit_t c;
        if (valid !== 1'b1) begin
            return;
        end
        if (exp_q.size() == 0) begin
            $display("Commit on debug%0d at pc %h arrived with nothing outstanding", slot, pc);
            timing_errors++;
            return;
        end
        c = exp_q.pop_front();
        checked++;
        if (c.slot !== slot || c.cyc != cyc_cnt) begin
            $display("Commit of pc %h on debug%0d in cycle %0d, expected debug%0d in cycle %0d",
                     pc, slot, cyc_cnt, c.slot, c.cyc);
            timing_errors++;
        end
        if (pc !== c.pc || wen !== c.wen
            || (c.wen && (wnum !== c.wnum || wdata !== c.wdata))) begin
            $display("Error at %0t: pc %h wen %b r%0d=%h, expected pc %h wen %b r%0d=%h",
                     $time, pc, wen, wnum, wdata, c.pc, c.wen, c.wnum, c.wdata);
            value_errors++;
        end
    endtask

    // Sample, update the model, check and drive the next offer
    task automatic run_edge();
        logic xfer;
        cyc_cnt++;
        if (issue_ready_o !== exp_ready) begin
            $display("Error at %0t: issue_ready_o is %b, expected %b", $time, issue_ready_o,
                     exp_ready);
            value_errors++;
        end
        xfer      = issue_valid_i === 1'b1 && issue_ready_o === 1'b1;
        exp_ready = 1'b1;
        if (xfer) begin
            exp_ready = !pair_dependent(issue_instr0_i, issue_instr1_i);   // Split stalls once
            model_execute(issue_instr0_i, issue_pc_i, 1'b0, cyc_cnt + 2);
            model_execute(issue_instr1_i, issue_pc_i + 32'd4, 1'b1,
                          exp_ready ? cyc_cnt + 2 : cyc_cnt + 3);
        end
        check_slot(1'b0, debug0_wb_valid_o, debug0_wb_pc_o, debug0_wb_rf_wen_o,
                   debug0_wb_rf_wnum_o, debug0_wb_rf_wdata_o);
        check_slot(1'b1, debug1_wb_valid_o, debug1_wb_pc_o, debug1_wb_rf_wen_o,
                   debug1_wb_rf_wnum_o, debug1_wb_rf_wdata_o);
        while (exp_q.size() != 0 && exp_q[0].cyc <= cyc_cnt) begin
            $display("Commit of pc %h due in cycle %0d never appeared", exp_q[0].pc, exp_q[0].cyc);
            exp_q.delete(0);
            timing_errors++;
        end
        if (issue_valid_i === 1'b1 && !xfer) begin
            return;   // Hold the offer stable until it is taken
        end
        if (exp_ready && pairs_sent < NUM_PAIRS && $urandom_range(0, 3) != 0) begin
            issue_valid_i  <= 1'b1;
            issue_pc_i     <= next_pc;
            issue_instr0_i <= random_instr();
            issue_instr1_i <= random_instr();
            next_pc = next_pc + 32'd8;
            pairs_sent++;
        end else begin
            issue_valid_i <= 1'b0;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        reset_i        = 1'b1;
        issue_valid_i  = 1'b0;
        issue_pc_i     = '0;
        issue_instr0_i = '0;
        issue_instr1_i = '0;
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;
        while (pairs_sent < NUM_PAIRS || issue_valid_i === 1'b1 || exp_q.size() != 0) begin
            @(posedge clk);
            run_edge();
        end
        repeat (4) begin
            @(posedge clk);
            run_edge();   // Catch stray commits
        end
        $display("Checked %0d commits: %0d value errors, %0d timing errors", checked,
                 value_errors, timing_errors);
        if (value_errors == 0 && timing_errors == 0 && checked == 2 * NUM_PAIRS) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(MAX_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not complete", MAX_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- sim.f
common/core_pkg.sv
common/pipe_if.sv
hw/dispatch.sv
hw/regfile.sv
hw/lane/alu_lane.sv
hw/commit.sv
hw/core_top.sv
test/core_sva.sv
test/core_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module core_tb -o core_sim

./obj_dir/core_sim | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
